/* common/spi_ctrl_pkg.sv */
// State encoding for the SPI frame controller
// Imported by the controller for its state register and assertion messages

package spi_ctrl_pkg;

    //------------------------------------------------------------
    // Frame controller states
    //------------------------------------------------------------
    typedef enum logic [2:0] {
        st_idle       = 3'd0,   // cs_n high, waiting for a frame
        st_cmd        = 3'd1,   // Shifting in address and flag
        st_fetch      = 3'd2,   // Memory read issued
        st_read_data  = 3'd3,   // Data byte going out on miso
        st_write_data = 3'd4,   // Data byte coming in on mosi
        st_commit     = 3'd5,   // One-clock write strobe
        st_done       = 3'd6    // Frame finished, wait for cs_n high
    } ctrl_state_e;

endpackage

/* common/spi_frame_pkg.sv */
// SPI frame format shared by the slave controller, shift register and memory
// Import wherever byte widths or the read/write flag are needed

package spi_frame_pkg;

    //------------------------------------------------------------
    // Byte and frame geometry
    //------------------------------------------------------------
    localparam int byte_bits  = 8;              // One SPI transfer unit
    localparam int frame_bits = 2 * byte_bits;  // Command byte plus data byte

    // Flag is the last bit shifted in, so it lands in the LSB
    // Address occupies the bits above it, MSB first
    localparam int rw_flag_pos = 0;

    //------------------------------------------------------------
    // Transfer direction, as carried by the flag bit
    //------------------------------------------------------------
    typedef enum logic {
        dir_write = 1'b0,   // Second byte comes in on mosi
        dir_read  = 1'b1    // Second byte goes out on miso
    } xfer_dir_e;

endpackage

/* spi_slave/spi_frame_fsm.sv */
// Frame controller for the SPI memory slave
// Counts sclk edges, latches the address and steers shift register and memory

`timescale 1ns/1ns

module spi_frame_fsm
    import spi_frame_pkg::*;
    import spi_ctrl_pkg::*;
#(
    parameter int addr_width = 7    // Memory address bits, at most byte_bits-1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cs_n_level,
    input  logic                  cs_n_fall,
    input  logic                  sclk_rise,
    input  logic                  sclk_fall,
    input  logic [byte_bits-1:0]  sr_byte,      // Parallel view of shift register
    output logic                  sr_shift_in,
    output logic                  sr_shift_out,
    output logic                  sr_load,
    output logic                  sr_out_en,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [addr_width-1:0] mem_addr
);

    localparam int cnt_w = $clog2(frame_bits + 1);

    ctrl_state_e           state;
    logic [cnt_w-1:0]      bit_cnt;     // sclk rises seen this frame
    logic [addr_width-1:0] addr_q;      // Address latch
    logic                  load_q;      // mem_re delayed, read data is ready
    xfer_dir_e             cmd_dir;

    // Flag straight off the command byte
    assign cmd_dir = xfer_dir_e'(sr_byte[rw_flag_pos]);

    //------------------------------------------------------------
    // State and bit counter
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            load_q  <= 1'b0;
        end else begin
            load_q <= mem_re;

            if (cs_n_level) begin
                state <= st_idle;   // Frame aborted or finished, never writes
            end else begin
                case (state)
                    st_idle: begin
                        if (cs_n_fall) begin
                            state   <= st_cmd;
                            bit_cnt <= '0;
                        end
                    end
                    st_cmd: begin
                        // Command byte is whole one clock after the 8th rise
                        if (bit_cnt == cnt_w'(byte_bits)) begin
                            state <= (cmd_dir == dir_read) ? st_fetch : st_write_data;
                        end else if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    st_fetch: state <= st_read_data;    // mem_re goes out here
                    st_read_data: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == cnt_w'(frame_bits - 1)) begin
                                state <= st_done;       // Master took the last bit
                            end
                        end
                    end
                    st_write_data: begin
                        if (bit_cnt == cnt_w'(frame_bits)) begin
                            state <= st_commit;
                        end else if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    st_commit: state <= st_done;
                    st_done:   state <= st_done;         // Hold until cs_n rises
                    default:   state <= st_idle;
                endcase
            end
        end
    end

    // Address taken from the upper bits of the command byte
    always_ff @(posedge clk) begin
        if (state == st_cmd && bit_cnt == cnt_w'(byte_bits)) begin
            addr_q <= sr_byte[byte_bits-1 -: addr_width];
        end
    end

    //------------------------------------------------------------
    // Command outputs
    //------------------------------------------------------------
    assign sr_shift_in  = sclk_rise &&
                          ((state == st_cmd && bit_cnt < cnt_w'(byte_bits)) ||
                           (state == st_write_data && bit_cnt < cnt_w'(frame_bits)));
    assign sr_shift_out = sclk_fall && state == st_read_data;  // Mode 0, change on fall
    assign sr_load      = load_q;                              // rd_data valid now
    assign sr_out_en    = state == st_read_data && !cs_n_level;
    assign mem_re       = state == st_fetch;
    assign mem_we       = state == st_commit;
    assign mem_addr     = addr_q;

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    // Single write strobe per frame
    assert property (@(posedge clk) disable iff (!rst_n) mem_we |=> !mem_we)
        else $error("mem_we held for two clocks, state %s", state.name());

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && mem_re))
        else $error("mem_we and mem_re together, state %s", state.name());

    // cs_n high always ends the frame
    assert property (@(posedge clk) disable iff (!rst_n) cs_n_level |=> state == st_idle)
        else $error("cs_n high but state %s", state.name());

endmodule

/* spi_slave/spi_shift_register.sv */
// Byte shift register between the SPI pins and the memory
// Shifts mosi in, loads read data, and drives a registered miso with enable

`timescale 1ns/1ns

module spi_shift_register
    import spi_frame_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 shift_in,      // Take mosi, on sclk rise
    input  logic                 shift_out,     // Next bit to miso, on sclk fall
    input  logic                 load,          // Parallel load from memory
    input  logic                 out_en,
    input  logic                 mosi_level,
    input  logic [byte_bits-1:0] load_data,
    output logic [byte_bits-1:0] par_out,
    output logic                 miso,
    output logic                 miso_en        // Pad drive enable
);

    logic [byte_bits-1:0] shreg;

    // Data path, MSB first in both directions
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= load_data;
        end else if (shift_in) begin
            shreg <= {shreg[byte_bits-2:0], mosi_level};
        end else if (shift_out) begin
            shreg <= {shreg[byte_bits-2:0], 1'b0};  // Top bit already on miso
        end
    end

    //------------------------------------------------------------
    // Pin side
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miso    <= 1'b0;
            miso_en <= 1'b0;
        end else begin
            miso_en <= out_en;
            if (shift_out) begin
                miso <= shreg[byte_bits-1];
            end
        end
    end

    assign par_out = shreg;

    // Controller never loads while a mosi bit arrives
    assert property (@(posedge clk) disable iff (!rst_n) !(load && shift_in))
        else $error("Shift register load and shift_in in the same clock");

endmodule

/* src.f */
common/spi_frame_pkg.sv
common/spi_ctrl_pkg.sv
src/input_conditioner.sv
spi_slave/spi_shift_register.sv
spi_slave/spi_frame_fsm.sv
src/data_memory.sv
src/spi_memory.sv
testbench/spi_memory_checker.sv
testbench/tb_spi_memory.sv

/* src/data_memory.sv */
// Byte-wide single-port memory for the SPI slave
// Write on we, registered read on re, rd_data valid one clock after re

`timescale 1ns/1ns

module data_memory
    import spi_frame_pkg::*;
#(
    parameter int addr_width = 7    // Depth is 2**addr_width bytes
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic                  re,
    input  logic [addr_width-1:0] addr,
    input  logic [byte_bits-1:0]  wr_data,
    output logic [byte_bits-1:0]  rd_data
);

    localparam int depth = 2 ** addr_width;

    logic [byte_bits-1:0] mem [depth];  // Contents survive reset

    //------------------------------------------------------------
    // Write port
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    //------------------------------------------------------------
    // Read port
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (re) begin
            rd_data <= mem[addr];   // Held until next re
        end
    end

endmodule

/* src/input_conditioner.sv */
// Pin conditioner for an asynchronous input
// Synchronizes and debounces one pin, gives a clean level and edge pulses

`timescale 1ns/1ns

module input_conditioner #(
    parameter int sync_stages     = 2,  // Synchronizer depth
    parameter int debounce_cycles = 2   // Clocks a new level must hold
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pin,       // Raw asynchronous pin
    output logic level,     // Debounced level
    output logic rise,      // One-clock pulse on 0->1
    output logic fall       // One-clock pulse on 1->0
);

    localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;

    logic [sync_stages-1:0] sync_q;     // [0] sees the pin first
    logic [cnt_w-1:0]       stable_cnt; // Clocks the synced value has differed
    logic                   level_prev;
    logic                   synced;

    assign synced = sync_q[sync_stages-1];

    //------------------------------------------------------------
    // Synchronizer chain and debounce counter
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q     <= '0;
            stable_cnt <= '0;
            level      <= 1'b0;
            level_prev <= 1'b0;
        end else begin
            sync_q[0] <= pin;
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end

            level_prev <= level;

            if (synced == level) begin
                stable_cnt <= '0;                       // Glitch gone, start over
            end else if (stable_cnt == cnt_w'(debounce_cycles - 1)) begin
                level      <= synced;                   // Held long enough
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // Edges from the accepted level only
    assign rise = level & ~level_prev;
    assign fall = ~level & level_prev;

endmodule

/* src/spi_memory.sv */
// SPI-attached byte memory, mode 0 slave on a fast system clock
// miso and miso_en go to an external pad buffer

`timescale 1ns/1ns

module spi_memory
    import spi_frame_pkg::*;
#(
    parameter int addr_width      = 7,
    parameter int sync_stages     = 2,
    parameter int debounce_cycles = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic miso_en
);

    logic                  cs_n_level, cs_n_fall;
    logic                  sclk_rise, sclk_fall;
    logic                  mosi_level;
    logic                  sr_shift_in, sr_shift_out, sr_load, sr_out_en;
    logic                  mem_we, mem_re;
    logic [addr_width-1:0] mem_addr;
    logic [byte_bits-1:0]  sr_byte;
    logic [byte_bits-1:0]  rd_data;

    //------------------------------------------------------------
    // Pin conditioners
    //------------------------------------------------------------
    input_conditioner #(
        .sync_stages     (sync_stages),
        .debounce_cycles (debounce_cycles)
    ) cs_n_cond_i (
        .clk (clk), .rst_n (rst_n), .pin (cs_n),
        .level (cs_n_level), .rise (), .fall (cs_n_fall)
    );

    input_conditioner #(
        .sync_stages     (sync_stages),
        .debounce_cycles (debounce_cycles)
    ) sclk_cond_i (
        .clk (clk), .rst_n (rst_n), .pin (sclk),
        .level (), .rise (sclk_rise), .fall (sclk_fall)    // Only edges matter
    );

    input_conditioner #(
        .sync_stages     (sync_stages),
        .debounce_cycles (debounce_cycles)
    ) mosi_cond_i (
        .clk (clk), .rst_n (rst_n), .pin (mosi),
        .level (mosi_level), .rise (), .fall ()
    );

    //------------------------------------------------------------
    // Slave and memory
    //------------------------------------------------------------
    spi_frame_fsm #(.addr_width (addr_width)) frame_fsm_i (
        .clk (clk), .rst_n (rst_n),
        .cs_n_level (cs_n_level), .cs_n_fall (cs_n_fall),
        .sclk_rise (sclk_rise), .sclk_fall (sclk_fall), .sr_byte (sr_byte),
        .sr_shift_in (sr_shift_in), .sr_shift_out (sr_shift_out),
        .sr_load (sr_load), .sr_out_en (sr_out_en),
        .mem_we (mem_we), .mem_re (mem_re), .mem_addr (mem_addr)
    );

    spi_shift_register shift_reg_i (
        .clk (clk), .rst_n (rst_n),
        .shift_in (sr_shift_in), .shift_out (sr_shift_out),
        .load (sr_load), .out_en (sr_out_en),
        .mosi_level (mosi_level), .load_data (rd_data),
        .par_out (sr_byte), .miso (miso), .miso_en (miso_en)
    );

    // Write data comes straight from the shift register
    data_memory #(.addr_width (addr_width)) data_memory_i (
        .clk (clk), .we (mem_we), .re (mem_re),
        .addr (mem_addr), .wr_data (sr_byte), .rd_data (rd_data)
    );

endmodule

/* testbench/spi_memory_checker.sv */
// Frame decoder and scoreboard on the SPI memory pins
// Keeps a model of the memory, compares read bytes and checks miso_en

`timescale 1ns/1ns

module spi_memory_checker #(
    parameter int addr_width = 7
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    input  logic miso,
    input  logic miso_en,
    output int   error_count,
    output int   reads_checked,
    output int   frames_closed
);

    localparam int depth = 2 ** addr_width;

    logic [7:0]            ref_mem   [depth];
    bit                    ref_valid [depth];
    logic                  sclk_q;
    logic                  cs_n_q;
    logic                  in_frame;
    int                    bit_idx;     // sclk rises seen in this frame
    logic [7:0]            shift_q;     // Command, then data byte
    logic                  is_read;
    logic [addr_width-1:0] addr_q;

    // Write updates the model, both directions return the stored byte
    function logic [7:0] ref_access(input logic rd, input logic [addr_width-1:0] addr,
                                    input logic [7:0] wdata);
        if (!rd) begin
            ref_mem[addr]   = wdata;
            ref_valid[addr] = 1'b1;
        end
        return ref_mem[addr];
    endfunction

    //------------------------------------------------------------
    // Pin watcher, sampled on clk so sclk edges are seen one clock late
    //------------------------------------------------------------
    always @(posedge clk) begin : watch_pins
        int         errs;
        logic [7:0] byte_now;
        logic [7:0] expected;
        errs = 0;
        if (!rst_n) begin
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
            in_frame <= 1'b0;
            bit_idx  <= 0;
        end else begin
            sclk_q <= sclk;
            cs_n_q <= cs_n;
            if (cs_n && miso_en !== 1'b0) begin
                $display("MISMATCH at %0t: miso_en %b while cs_n high", $time, miso_en);
                errs++;
            end
            if (cs_n_q && !cs_n) begin                   // Frame opens
                in_frame <= 1'b1;
                bit_idx  <= 0;
            end else if (!cs_n_q && cs_n && in_frame) begin
                in_frame      <= 1'b0;                   // Short frames end here too
                frames_closed <= frames_closed + 1;
            end else if (in_frame && !cs_n && sclk && !sclk_q && bit_idx < 16) begin
                byte_now = {shift_q[6:0], (bit_idx >= 8 && is_read) ? miso : mosi};
                shift_q <= byte_now;
                bit_idx <= bit_idx + 1;
                if (miso_en !== (bit_idx >= 8 && is_read)) begin
                    $display("MISMATCH at %0t: miso_en %b at sclk rise %0d",
                             $time, miso_en, bit_idx + 1);
                    errs++;
                end
                if (bit_idx == 7) begin
                    is_read <= byte_now[0];              // Flag is the last command bit
                    addr_q  <= byte_now[7 -: addr_width];
                end
                if (bit_idx == 15 && !is_read) begin
                    expected = ref_access(1'b0, addr_q, byte_now);
                end else if (bit_idx == 15 && !ref_valid[addr_q]) begin
                    $display("Read at %0t from address %h that was never written",
                             $time, addr_q);
                    errs++;
                end else if (bit_idx == 15) begin
                    expected      = ref_access(1'b1, addr_q, 8'h00);
                    reads_checked <= reads_checked + 1;
                    if (byte_now !== expected) begin
                        $display("MISMATCH at %0t: address %h expected %h actual %h",
                                 $time, addr_q, expected, byte_now);
                        errs++;
                    end
                end
            end
        end
        error_count <= error_count + errs;
    end

endmodule

/* testbench/tb_spi_memory.sv */
// Testbench for the SPI byte memory, acting as a mode 0 SPI master
// Frames go out on the pins, spi_memory_checker decodes them and compares reads

`timescale 1ns/1ns

module tb_spi_memory;

    localparam int addr_width    = 7;
    localparam int half_clks     = 8;       // sclk half-period in clk cycles
    localparam int normal_gap    = 6;       // cs_n high time, in sclk half-periods
    localparam int short_gap     = 4;       // Back-to-back frames
    localparam int frame_timeout = 400;     // clk cycles to wait for a frame close

    logic clk;
    logic rst_n;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic miso_en;

    int          error_count;               // From the checker
    int          reads_checked;
    int          frames_closed;
    int          frames_sent;
    int          timeouts;
    logic [31:0] rng_state;
    bit          written [2**addr_width];   // Addresses that hold a known byte

    //------------------------------------------------------------
    // Clock, DUT and checker
    //------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;             // 100 ns period
    end

    spi_memory #(.addr_width (addr_width)) spi_memory_i (
        .clk (clk), .rst_n (rst_n), .sclk (sclk), .cs_n (cs_n), .mosi (mosi),
        .miso (miso), .miso_en (miso_en)
    );

    spi_memory_checker #(.addr_width (addr_width)) checker_i (
        .clk (clk), .rst_n (rst_n), .sclk (sclk), .cs_n (cs_n), .mosi (mosi),
        .miso (miso), .miso_en (miso_en), .error_count (error_count),
        .reads_checked (reads_checked), .frames_closed (frames_closed)
    );

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic wait_halves(input int halves);
        repeat (halves * half_clks) @(posedge clk);
    endtask

    // Waits until the checker has closed every frame sent so far
    task automatic wait_frames_closed(input int target);
        int waited;
        waited = 0;
        while (frames_closed < target && waited < frame_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (frames_closed < target) begin
            $display("Timeout at %0t: checker closed %0d of %0d frames",
                     $time, frames_closed, target);
            timeouts++;
        end
    endtask

    // One frame, cut short when rises is below 16
    task automatic spi_transfer(input logic [addr_width-1:0] addr, input logic rd,
                                input logic [7:0] wdata, input int rises, input int gap);
        logic [15:0] word;
        if (timeouts > 0) return;           // Run is already lost
        word                   = '0;
        word[15 -: addr_width] = addr;      // Address in the upper command bits
        word[8]                = rd;
        word[7:0]              = wdata;
        @(posedge clk);
        cs_n <= 1'b0;
        mosi <= word[15];
        wait_halves(1);
        for (int i = 0; i < rises; i++) begin
            sclk <= 1'b1;                   // Slave samples here
            wait_halves(1);
            sclk <= 1'b0;
            if (i < 15) begin
                mosi <= word[14 - i];       // Next bit set up on the fall
            end
            wait_halves(1);
        end
        cs_n <= 1'b1;
        mosi <= 1'b0;
        frames_sent++;
        wait_halves(gap);
        wait_frames_closed(frames_sent);
    endtask

    task automatic write_byte(input logic [addr_width-1:0] addr, input logic [7:0] data,
                              input int gap);
        spi_transfer(addr, 1'b0, data, 16, gap);
        written[addr] = 1'b1;
    endtask

    task automatic read_byte(input logic [addr_width-1:0] addr, input int gap);
        spi_transfer(addr, 1'b1, 8'h00, 16, gap);
    endtask

    task automatic finish_run();
        $display("Errors: %0d checker, %0d timeouts; reads checked %0d, frames %0d",
                 error_count, timeouts, reads_checked, frames_closed);
        if (error_count == 0 && timeouts == 0 && reads_checked > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------
    initial begin
        logic [addr_width-1:0] addr;
        logic [addr_width-1:0] prev_addr;
        logic [7:0]            data;
        rst_n       <= 1'b0;
        sclk        <= 1'b0;
        cs_n        <= 1'b1;
        mosi        <= 1'b0;
        frames_sent = 0;
        timeouts    = 0;
        rng_state   = 32'h6cdc;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_halves(4);                     // Conditioners settle on cs_n high

        // Single write and read back
        write_byte(7'h12, 8'h5a, normal_gap);
        read_byte(7'h12, normal_gap);

        // Random writes, repeats allowed so later writes overwrite
        for (int n = 0; n < 64; n++) begin
            rng_state = next_random(rng_state);
            write_byte(rng_state[addr_width-1:0], rng_state[15:8], normal_gap);
        end
        for (int a = 0; a < 2**addr_width; a++) begin
            if (written[a]) begin
                read_byte(a[addr_width-1:0], normal_gap);
            end
        end

        // Aborted writes must leave the old byte
        spi_transfer(7'h12, 1'b0, 8'hc3, 12, normal_gap);
        spi_transfer(7'h12, 1'b0, 8'h3c, 15, normal_gap);
        read_byte(7'h12, normal_gap);

        // Back-to-back, reads trail the writes by one
        prev_addr = 7'h12;
        for (int n = 0; n < 20; n++) begin
            rng_state = next_random(rng_state);
            addr      = rng_state[addr_width-1:0];
            data      = rng_state[15:8];
            write_byte(addr, data, short_gap);
            read_byte(prev_addr, short_gap);
            prev_addr = addr;
        end
        read_byte(prev_addr, normal_gap);

        finish_run();
    end

endmodule
